/* src/spi_frame_pkg.sv */
// sequence values assume sclk = clk/2 and one 16-bit frame per chip select, no daisy chain
`default_nettype none

package spi_frame_pkg;

    // bits per frame, sent and received msb first
    localparam int FRAME_BITS = 16;

    // max7317 frame word
    // d15 is the r/w flag, d14:d8 the register address, d7:d0 the data byte
    typedef struct packed {
        logic       rw;    // 1 = read
        logic [6:0] addr;  // register address inside the expander
        logic [7:0] data;  // port data, ignored by the chip on a read
    } ioexp_frame_t;

    // sequence counter, one step per clk
    typedef logic [5:0] seq_t;

    // cycles 0..31 carry sclk, high on odd counts
    localparam seq_t SEQ_SHIFT_END = 6'd32;

    // cs_n stays high this many cycles after the last bit before the frame ends
    localparam seq_t SEQ_CS_HOLD = 6'd2;

    // final count of a frame; last_rx and pending update here
    localparam seq_t SEQ_LAST = SEQ_SHIFT_END + SEQ_CS_HOLD;

endpackage

`default_nettype wire

/* src/host_reg_pkg.sv */
// register map for two expanders only; host reads return status zero-extended to 32 bits
`default_nettype none

package host_reg_pkg;

    import spi_frame_pkg::*;

    // one expander per spi chip select
    localparam int NUM_CHIPS = 2;

    // host register addresses, one per chip
    localparam logic [15:0] REG_IOEXP0 = 16'h0010;
    localparam logic [15:0] REG_IOEXP1 = 16'h0011;

    // host write beat, taken when host_wr_valid and host_wr_ready are both high
    typedef struct packed {
        logic [15:0]  addr;  // selects the chip
        ioexp_frame_t data;  // frame sent as is
    } host_wr_t;

    // per-engine status, also the host read word
    typedef struct packed {
        logic         pending;  // command held, frame not yet finished
        logic         active;   // engine owns the spi lines right now
        ioexp_frame_t last_rx;  // echo captured by the latest frame
    } ioexp_status_t;

endpackage

`default_nettype wire

/* src/ioexp_frame_engine.sv */
// one frame per command at sclk = clk/2; engine drives sclk/mosi only while bus_gnt is held
`timescale 1ns/1ps
`default_nettype none

module ioexp_frame_engine
    import spi_frame_pkg::*;
    import host_reg_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire ioexp_frame_t  cmd,        // frame to send
    input  wire                cmd_valid,
    output logic               cmd_ready,  // low while a frame is held
    output logic               bus_req,    // asks the arbiter for the spi lines
    input  wire                bus_gnt,
    input  wire                miso,       // echo from the chip
    output logic               eng_sclk,
    output logic               eng_mosi,
    output logic               cs_n,       // this chip's select, active low
    output ioexp_status_t      status
);

    //   seq    0  1   2   3   4   5  ..  31  32 33 34
    //   sclk   ___|---|___|---|___|--- .. ---|________
    //   mosi   b15    b14     b13          b0
    //   miso sampled at the end of each odd count

    ioexp_frame_t tx_frame;  // latched command
    ioexp_frame_t rx_frame;  // bits collected from miso
    ioexp_frame_t last_rx;   // published at SEQ_LAST
    seq_t         seq;       // position inside the frame
    logic         pending;   // from command accept to SEQ_LAST
    logic         running;   // pending and granted, counter advances
    logic         shifting;  // chip selected, bits moving
    logic [3:0]   bit_idx;   // frame bit on the line, 0 = msb
    logic         take_cmd;

    assign take_cmd = cmd_valid & cmd_ready;
    assign running  = pending & bus_gnt;
    assign shifting = running & (seq < SEQ_SHIFT_END);
    assign bit_idx  = seq[4:1];  // two counts per bit

    assign cmd_ready = ~pending;
    assign bus_req   = pending;  // high the cycle after accept until the frame ends

    // line outputs stay low outside the frame so the arbiter mux sees clean zeros
    assign cs_n     = ~shifting;
    assign eng_sclk = shifting & seq[0];                             // rising edge on odd counts
    assign eng_mosi = shifting & tx_frame[FRAME_BITS - 1 - bit_idx];  // changes on even counts

    assign status = '{pending: pending, active: running, last_rx: last_rx};

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            seq     <= '0;
            last_rx <= '0;       // status reads zero after reset
        end else if (take_cmd) begin
            pending <= 1'b1;     // bus_req follows next cycle
        end else if (running) begin
            if (seq == SEQ_LAST) begin
                pending <= 1'b0;  // drops bus_req, frees the command slot
                seq     <= '0;
                last_rx <= rx_frame;
            end else begin
                seq <= seq + 6'd1;
            end
        end
    end

    // frame payload
    always_ff @(posedge clk) begin
        if (take_cmd) begin
            tx_frame <= cmd;
        end
        if (shifting && seq[0]) begin
            rx_frame[FRAME_BITS - 1 - bit_idx] <= miso;  // last bit lands at count 31
        end
    end

    // chip select falls only after this engine asked for the bus and was granted
    a_cs_needs_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        !cs_n |-> bus_gnt && $past(bus_req));

    // sclk rises no earlier than one full cycle after cs_n went low
    a_sclk_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        eng_sclk |-> !cs_n && $past(!cs_n));

endmodule

`default_nettype wire

/* src/spi_bus_arbiter.sv */
// two requesters only; grant is registered, so it arrives one cycle after bus_req rises
`timescale 1ns/1ps
`default_nettype none

module spi_bus_arbiter (
    input  wire        clk,
    input  wire        rst_n,
    input  wire  [1:0] bus_req,   // one bit per engine
    input  wire  [1:0] eng_sclk,
    input  wire  [1:0] eng_mosi,
    output logic [1:0] bus_gnt,   // one-hot or zero
    output logic       sclk,      // shared spi clock
    output logic       mosi       // shared data to the chips
);

    logic [1:0] gnt_next;
    logic       last_served;  // engine granted most recently
    logic       holder_busy;  // current owner still requests

    assign holder_busy = |(bus_gnt & bus_req);

    // grant moves only once the owner lets go
    always_comb begin
        gnt_next = bus_gnt;
        if (!holder_busy) begin
            if (&bus_req) begin
                gnt_next = last_served ? 2'b01 : 2'b10;  // the other one goes first
            end else begin
                gnt_next = bus_req;  // single requester or idle bus
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_gnt     <= '0;
            last_served <= 1'b0;
        end else begin
            bus_gnt <= gnt_next;
            if (|gnt_next) begin
                last_served <= gnt_next[1];
            end
        end
    end

    // and-or mux gives zero with no grant
    assign sclk = |(bus_gnt & eng_sclk);
    assign mosi = |(bus_gnt & eng_mosi);

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(bus_gnt));

endmodule

`default_nettype wire

/* src/ioexp_host_regs.sv */
// writes to unknown addresses are taken and dropped; one command per chip in flight
`timescale 1ns/1ps
`default_nettype none

module ioexp_host_regs
    import spi_frame_pkg::*;
    import host_reg_pkg::*;
(
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire host_wr_t                      host_wr,
    input  wire                                host_wr_valid,
    output logic                               host_wr_ready,
    input  wire [15:0]                         host_raddr,
    output logic [31:0]                        host_rdata,
    output ioexp_frame_t [NUM_CHIPS-1:0]       cmd,        // per-engine frame
    output logic [NUM_CHIPS-1:0]               cmd_valid,  // one cycle per command
    input  wire [NUM_CHIPS-1:0]                cmd_ready,
    input  wire ioexp_status_t [NUM_CHIPS-1:0] status
);

    logic wr_hit;   // write address is a chip register
    logic wr_chip;  // chip addressed by the write
    logic rd_hit;
    logic rd_chip;
    logic wr_take;  // write beat accepted

    // address to {hit, chip index}
    function automatic logic [1:0] decode_addr(input logic [15:0] addr);
        logic [1:0] hit_idx;
        case (addr)
            REG_IOEXP0: hit_idx = 2'b10;
            REG_IOEXP1: hit_idx = 2'b11;
            default:    hit_idx = 2'b00;
        endcase
        return hit_idx;
    endfunction

    assign {wr_hit, wr_chip} = decode_addr(host_wr.addr);
    assign {rd_hit, rd_chip} = decode_addr(host_raddr);

    // hold off while the addressed engine has a command, including
    // the cycle where cmd_valid is out but pending has not yet risen
    assign host_wr_ready = ~wr_hit | (cmd_ready[wr_chip] & ~cmd_valid[wr_chip]);
    assign wr_take       = host_wr_valid & host_wr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid <= '0;
        end else begin
            cmd_valid <= '0;  // pulse, the engine takes it on the next edge
            if (wr_take && wr_hit) begin
                cmd_valid[wr_chip] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take && wr_hit) begin
            cmd[wr_chip] <= host_wr.data;
        end
    end

    // status word zero-extended, zero for unknown addresses
    assign host_rdata = rd_hit ? 32'(status[rd_chip]) : 32'd0;

    // a command pulse must always land on an engine that can take it
    a_cmd_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid & ~cmd_ready) == '0);

endmodule

`default_nettype wire

/* src/ioexp_top.sv */
// two MAX7317 on one spi bus at sclk = clk/2; miso must be low whenever no chip is selected
`timescale 1ns/1ps
`default_nettype none

module ioexp_top
    import spi_frame_pkg::*;
    import host_reg_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire host_wr_t        host_wr,
    input  wire                  host_wr_valid,
    output logic                 host_wr_ready,
    input  wire [15:0]           host_raddr,
    output logic [31:0]          host_rdata,
    input  wire                  miso,   // shared by both chips
    output logic                 sclk,
    output logic                 mosi,
    output logic [NUM_CHIPS-1:0] cs_n    // one select per chip
);

    ioexp_frame_t  [NUM_CHIPS-1:0] cmd;
    ioexp_status_t [NUM_CHIPS-1:0] status;
    logic [NUM_CHIPS-1:0]          cmd_valid;
    logic [NUM_CHIPS-1:0]          cmd_ready;
    logic [NUM_CHIPS-1:0]          bus_req;
    logic [NUM_CHIPS-1:0]          bus_gnt;
    logic [NUM_CHIPS-1:0]          eng_sclk;
    logic [NUM_CHIPS-1:0]          eng_mosi;

    ioexp_host_regs u_regs (
        .clk,
        .rst_n,
        .host_wr,
        .host_wr_valid,
        .host_wr_ready,
        .host_raddr,
        .host_rdata,
        .cmd,
        .cmd_valid,
        .cmd_ready,
        .status
    );

    // one frame engine per expander
    for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_eng
        ioexp_frame_engine u_eng (
            .clk,
            .rst_n,
            .cmd       (cmd[i]),
            .cmd_valid (cmd_valid[i]),
            .cmd_ready (cmd_ready[i]),
            .bus_req   (bus_req[i]),
            .bus_gnt   (bus_gnt[i]),
            .miso,                       // fanned out, only the selected chip drives it
            .eng_sclk  (eng_sclk[i]),
            .eng_mosi  (eng_mosi[i]),
            .cs_n      (cs_n[i]),
            .status    (status[i])
        );
    end

    spi_bus_arbiter u_arb (
        .clk,
        .rst_n,
        .bus_req,
        .eng_sclk,
        .eng_mosi,
        .bus_gnt,
        .sclk,
        .mosi
    );

endmodule

`default_nettype wire

/* tests/max7317_model.sv */
// spi mode 0 only; miso is low while deselected so several models can be ORed onto one line
`timescale 1ns/1ps
`default_nettype none

module max7317_model
    import spi_frame_pkg::*;
(
    input  wire  sclk,
    input  wire  mosi,
    input  wire  cs_n,
    output logic miso
);

    logic [7:0]   port_reg [128];  // one byte per register address
    ioexp_frame_t rx_shift;        // frame coming in on mosi
    ioexp_frame_t tx_shift;        // echo going out on miso
    ioexp_frame_t reply;           // echo for the next frame
    logic         in_frame;        // set by a real falling edge of cs_n

    initial begin
        for (int a = 0; a < 128; a++) begin
            port_reg[a] = {1'b1, a[6:0]};  // power-up contents follow the address
        end
        reply    = '0;
        rx_shift = '0;
        tx_shift = '0;
        in_frame = 1'b0;
    end

    assign miso = ~cs_n & tx_shift[FRAME_BITS - 1];

    always @(negedge cs_n) begin
        in_frame = 1'b1;
        tx_shift = reply;  // msb goes out first
    end

    always @(posedge sclk) if (!cs_n) rx_shift <= {rx_shift[FRAME_BITS - 2:0], mosi};

    always @(negedge sclk) if (!cs_n) tx_shift <= {tx_shift[FRAME_BITS - 2:0], 1'b0};

    // frame complete, a read echoes the port byte, a write stores it
    always @(posedge cs_n) begin
        if (in_frame) begin
            reply = rx_shift;
            if (rx_shift.rw) begin
                reply.data = port_reg[rx_shift.addr];
            end else begin
                port_reg[rx_shift.addr] = rx_shift.data;
            end
            in_frame = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_ioexp_top.sv */
// run from the project root since stimulus comes from tests/ioexp_tests.txt; reads of unwritten ports are not modeled
`timescale 1ns/1ps
`default_nettype none

module tb_ioexp_top
    import spi_frame_pkg::*;
    import host_reg_pkg::*;
();

    logic                 clk;
    logic                 rst_n;
    host_wr_t             host_wr;
    logic                 host_wr_valid;
    logic                 host_wr_ready;
    logic [15:0]          host_raddr;
    logic [31:0]          host_rdata;
    logic                 miso;
    logic                 sclk;
    logic                 mosi;
    logic [NUM_CHIPS-1:0] cs_n;
    logic [NUM_CHIPS-1:0] chip_miso;

    string        t_name[$];
    string        t_op[$];
    int           t_chip[$];
    logic [15:0]  t_frame[$];
    logic [15:0]  t_exp[$];
    int           n_tests;
    bit           loaded;
    int           errors;
    logic [31:0]  rnd_state;
    ioexp_frame_t prev_frame [NUM_CHIPS];       // last frame sent per chip
    logic [7:0]   port_shadow [NUM_CHIPS][128];  // port bytes written per chip

    ioexp_top UUT (
        .clk,
        .rst_n,
        .host_wr,
        .host_wr_valid,
        .host_wr_ready,
        .host_raddr,
        .host_rdata,
        .miso,
        .sclk,
        .mosi,
        .cs_n
    );

    max7317_model u_chip0 (.sclk, .mosi, .cs_n(cs_n[0]), .miso(chip_miso[0]));
    max7317_model u_chip1 (.sclk, .mosi, .cs_n(cs_n[1]), .miso(chip_miso[1]));

    assign miso = |chip_miso;  // deselected chips drive low

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] chip_addr(input int chip);
        case (chip)
            0:       return REG_IOEXP0;
            1:       return REG_IOEXP1;
            default: return 16'h00F0;  // no register here
        endcase
    endfunction

    // echo is the previous frame with port data filled in on a read
    function automatic ioexp_frame_t expected_echo(input int chip);
        ioexp_frame_t echo;
        echo = prev_frame[chip];
        if (echo.rw) echo.data = port_shadow[chip][echo.addr];
        return echo;
    endfunction

    task automatic note_sent(input int chip, input ioexp_frame_t f);
        if (!f.rw) port_shadow[chip][f.addr] = f.data;
        prev_frame[chip] = f;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic load_tests(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        string       op;
        int          chip;
        logic [15:0] frame;
        logic [15:0] exp;
        ok = 1'b0;
        fd = $fopen("tests/ioexp_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin  // skip column notes
                    n = $sscanf(line, "%s %s %d %h %h", name, op, chip, frame, exp);
                    if (n == 5) begin
                        t_name.push_back(name);
                        t_op.push_back(op);
                        t_chip.push_back(chip);
                        t_frame.push_back(frame);
                        t_exp.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called 1 ns after an edge and returns 1 ns after the edge that took the beat
    task automatic put_write(input logic [15:0] addr, input logic [15:0] frame,
                             output int waited);
        waited        = 0;
        host_wr       = '{addr: addr, data: frame};
        host_wr_valid = 1'b1;
        #1;
        while (!host_wr_ready) begin
            @(posedge clk);
            #2;
            waited++;
        end
        @(posedge clk);
        #1;
        host_wr_valid = 1'b0;
    endtask

    task automatic read_word(input logic [15:0] addr, output logic [31:0] word);
        host_raddr = addr;
        #1;
        word = host_rdata;  // combinational from registered status
        @(posedge clk);
        #1;
    endtask

    task automatic wait_done(input int chip, output logic [31:0] word);
        ioexp_status_t st;
        @(posedge clk);  // pending rises one edge after the beat
        #1;
        host_raddr = chip_addr(chip);
        #1;
        st = ioexp_status_t'(host_rdata[$bits(ioexp_status_t)-1:0]);
        while (st.pending) begin
            @(posedge clk);
            #2;
            st = ioexp_status_t'(host_rdata[$bits(ioexp_status_t)-1:0]);
        end
        word = host_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input int i);
        ioexp_frame_t f;
        ioexp_frame_t f2;
        ioexp_frame_t echo;
        ioexp_frame_t echo_b;
        logic [31:0]  word;
        logic [31:0]  snap0;
        logic [31:0]  snap1;
        int           waited;
        f = t_frame[i];
        if (t_op[i] == "status") begin
            read_word(chip_addr(t_chip[i]), word);
            check_value(t_name[i], {16'h0, t_exp[i]}, word);
        end else if (t_op[i] == "write" && t_chip[i] < NUM_CHIPS) begin
            put_write(chip_addr(t_chip[i]), f, waited);
            note_sent(t_chip[i], f);
            wait_done(t_chip[i], word);
            check_value(t_name[i], {16'h0, t_exp[i]}, word);  // idle status with the echo in last_rx
        end else if (t_op[i] == "write") begin
            read_word(REG_IOEXP0, snap0);
            read_word(REG_IOEXP1, snap1);
            put_write(chip_addr(t_chip[i]), f, waited);
            check_true(waited == 0, "write to an unknown address was held off");
            repeat (4) @(posedge clk);
            #1;
            read_word(REG_IOEXP0, word);
            check_value({t_name[i], "_chip0"}, snap0, word);
            read_word(REG_IOEXP1, word);
            check_value({t_name[i], "_chip1"}, snap1, word);
        end else if (t_op[i] == "busy") begin
            f2 = f ^ 16'h00FF;  // second frame differs in data only
            put_write(chip_addr(t_chip[i]), f, waited);
            note_sent(t_chip[i], f);
            put_write(chip_addr(t_chip[i]), f2, waited);
            note_sent(t_chip[i], f2);
            check_true(waited >= 2 * FRAME_BITS, "second write to a busy chip was not held off");
            wait_done(t_chip[i], word);
            check_value(t_name[i], {16'h0, t_exp[i]}, word);
        end else if (t_op[i] == "pair") begin
            rnd_state = lcg_next(rnd_state);
            f.data    = rnd_state[23:16];
            f2        = t_frame[i];
            rnd_state = lcg_next(rnd_state);
            f2.data   = rnd_state[23:16];
            echo      = expected_echo(0);
            echo_b    = expected_echo(1);
            put_write(REG_IOEXP0, f, waited);
            put_write(REG_IOEXP1, f2, waited);  // both engines now ask for the bus
            check_true(waited == 0, "write to an idle chip was held off");
            note_sent(0, f);
            note_sent(1, f2);
            @(posedge clk);  // chip0 asked first and owns the bus while chip1 waits
            #1;
            read_word(REG_IOEXP0, word);
            check_value({t_name[i], "_owner"}, 32'h3, {30'h0, word[17:16]});
            read_word(REG_IOEXP1, word);
            check_value({t_name[i], "_waiter"}, 32'h2, {30'h0, word[17:16]});
            wait_done(0, word);
            check_value({t_name[i], "_chip0"}, {16'h0, echo}, word);
            wait_done(1, word);
            check_value({t_name[i], "_chip1"}, {16'h0, echo_b}, word);
        end else begin
            check_true(1'b0, {"unknown operation in test ", t_name[i]});
        end
    endtask

    // the two chips share sclk/mosi, so their selects must never overlap
    always @(posedge clk) begin
        if (rst_n) begin
            assert (cs_n != 2'b00) else begin
                $display("both chip selects low at %0t", $time);
                errors++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_tests * 200) @(posedge clk);
        $display("watchdog expired, tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        bit ok;
        int errs_before;
        int n_failed;
        clk           = 1'b0;
        rst_n         = 1'b0;
        host_wr       = '0;
        host_wr_valid = 1'b0;
        host_raddr    = '0;
        errors        = 0;
        n_failed      = 0;
        rnd_state     = 32'd60376;
        for (int c = 0; c < NUM_CHIPS; c++) begin
            prev_frame[c] = '0;  // models start with an all-zero echo
        end
        load_tests(ok);
        if (!ok) begin
            $display("cannot open tests/ioexp_tests.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            n_tests = t_name.size() + 1;  // plus the reset check
            loaded  = 1'b1;
            repeat (16) @(posedge clk);
            #1;
            rst_n = 1'b1;
            check_value("reset_cs_n", 32'h3, {30'h0, cs_n});
            check_value("reset_sclk", 32'h0, {31'h0, sclk});
            check_value("reset_mosi", 32'h0, {31'h0, mosi});
            check_value("reset_ready", 32'h1, {31'h0, host_wr_ready});
            if (errors == 0) begin
                $display("test %-12s ok", "reset_state");
            end else begin
                $display("test %-12s failed", "reset_state");
                n_failed++;
            end
            for (int i = 0; i < t_name.size(); i++) begin
                errs_before = errors;
                run_test(i);
                if (errors == errs_before) begin
                    $display("test %-12s ok", t_name[i]);
                end else begin
                    $display("test %-12s failed", t_name[i]);
                    n_failed++;
                end
            end
            $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
            if (errors == 0 && n_failed == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
src/spi_frame_pkg.sv
src/host_reg_pkg.sv
src/ioexp_frame_engine.sv
src/spi_bus_arbiter.sv
src/ioexp_host_regs.sv
src/ioexp_top.sv
tests/max7317_model.sv
tests/tb_ioexp_top.sv

/* tests/ioexp_tests.txt */
# name op chip frame expected, frame and expected in hex, chip 2 has no register
# op: write = frame and echo, status = host read, busy = back-to-back, pair = both chips
rst_status0  status 0 0000 0000
rst_status1  status 1 0000 0000
unk_rd_init  status 2 0000 0000
echo_first   write  0 0312 0000
echo_second  write  0 0434 0312
rb_write     write  1 0A55 0000
rb_read      write  1 8A00 0A55
rb_final     write  1 0000 8A55
unk_write    write  2 05AA 0000
unk_read     status 2 0000 0000
st_chip0     status 0 0000 0312
st_chip1     status 1 0000 8A55
busy_back    busy   0 0677 0677
pair_a       pair   0 0100 0000
pair_b       pair   0 0200 0000
